// File: verilog.f
source/lc4_pkg.sv
source/lc4_decoder.sv
source/lc4_regfile.sv
source/lc4_alu.sv
source/lc4_hazard_unit.sv
source/lc4_processor.sv
sim/lc4_tb.sv

// File: Bender.yml
package:
  name: lc4_pipeline

sources:
  - source/lc4_pkg.sv
  - source/lc4_decoder.sv
  - source/lc4_regfile.sv
  - source/lc4_alu.sv
  - source/lc4_hazard_unit.sv
  - source/lc4_processor.sv
  - target: simulation
    files:
      - sim/lc4_tb.sv

// File: sim/lc4_tb.sv
/*
   LC4 pipeline testbench
   Runs directed programs against an in-order reference model and
   compares the writeback trace and the store stream event by event
*/
`timescale 1ns/1ps

module lc4_tb import lc4_pkg::*; ();

   localparam int CLK_PERIOD = 10;
   localparam int IMEM_N     = 64;
   localparam int DMEM_N     = 65536;
   // Program sizes without the end marker
   localparam int N_CHAIN    = 11;
   localparam int N_LDST     = 9;
   localparam int N_BRANCH   = 27;
   localparam int N_RAND     = 40;
   localparam int TOTAL_INSNS = N_CHAIN + N_LDST + N_BRANCH + N_RAND + 4;
   localparam int WATCHDOG_CYCLES = TOTAL_INSNS * 4 + 50;

   logic     gwe;
   logic     rst_n;
   word_t    cur_pc, cur_insn;
   word_t    dmem_addr, dmem_data, dmem_towrite;
   logic     dmem_we;
   logic     wb_we;
   reg_sel_t wb_sel;
   word_t    wb_data, wb_pc;

   // Memories seen by the DUT and by the model
   word_t imem [IMEM_N];
   word_t dmem [DMEM_N];
   word_t mmem [DMEM_N];

   // Current program and the expected event streams
   word_t    prog [$];
   reg_sel_t exp_sel [$];
   word_t    exp_data [$];
   word_t    exp_pc [$];
   word_t    exp_addr [$];
   word_t    exp_store [$];
   int       tr_idx;
   int       st_idx;
   word_t    lfsr_state;

   lc4_processor lc4_processor_inst (
      .gwe             (gwe),
      .i_rst_n         (rst_n),
      .o_cur_pc        (cur_pc),
      .i_cur_insn      (cur_insn),
      .o_dmem_addr     (dmem_addr),
      .i_cur_dmem_data (dmem_data),
      .o_dmem_we       (dmem_we),
      .o_dmem_towrite  (dmem_towrite),
      .o_wb_we         (wb_we),
      .o_wb_sel        (wb_sel),
      .o_wb_data       (wb_data),
      .o_wb_pc         (wb_pc)
   );

   always #(CLK_PERIOD / 2) gwe = ~gwe;

   // Instruction encoders
   function automatic word_t reg_form(input opcode_e op, input reg_sel_t d, input reg_sel_t s,
                                      input logic [2:0] sub, input reg_sel_t t);
      return {op, d, s, sub, t};
   endfunction

   function automatic word_t imm5_form(input opcode_e op, input reg_sel_t d, input reg_sel_t s,
                                       input logic [4:0] imm);
      return {op, d, s, 1'b1, imm};
   endfunction

   function automatic word_t mem_form(input opcode_e op, input reg_sel_t d, input reg_sel_t s,
                                      input logic [5:0] imm);
      return {op, d, s, imm};
   endfunction

   // CONST and BR share the rd-or-mask plus imm9 layout
   function automatic word_t wide_form(input opcode_e op, input logic [2:0] d,
                                       input logic [8:0] imm);
      return {op, d, imm};
   endfunction

   // Galois LFSR stepped once per bit
   function automatic logic [8:0] lfsr_bits(input int n);
      logic [8:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[7:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   function automatic word_t fill_word(input word_t a);
      return {a[7:0], a[15:8]} ^ 16'h3C5A;
   endfunction

   function automatic word_t fetch_insn(input word_t pc);
      word_t off;
      off = pc - RESET_PC;
      if (int'(off) < IMEM_N) begin
         return imem[off[5:0]];
      end else begin
         return '0;
      end
   endfunction

   task automatic stop_on_error();
      $display("sim failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         stop_on_error();
      end
   endtask

   // Sequential ISA model that fills the expected streams
   task automatic run_model();
      word_t regs [REG_N];
      word_t insn, a, res, addr;
      word_t imm5, imm6, imm9;
      nzp_t  nzp;
      int    idx, steps;
      logic  wr;
      for (int r = 0; r < REG_N; r++) begin
         regs[r] = '0;
      end
      nzp   = '0;
      idx   = 0;
      steps = 0;
      exp_sel.delete();
      exp_data.delete();
      exp_pc.delete();
      exp_addr.delete();
      exp_store.delete();
      while (idx < prog.size() && steps < 1000) begin
         insn = prog[idx];
         a    = regs[insn[8:6]];
         imm5 = {{11{insn[4]}}, insn[4:0]};
         imm6 = {{10{insn[5]}}, insn[5:0]};
         imm9 = {{7{insn[8]}}, insn[8:0]};
         addr = a + imm6;
         wr   = 1'b1;
         res  = '0;
         case (insn[15:12])
            OP_ARITH: begin
               if (insn[5]) res = a + imm5;
               else if (insn[4:3] == 2'b00) res = a + regs[insn[2:0]];
               else if (insn[4:3] == 2'b10) res = a - regs[insn[2:0]];
               else wr = 1'b0;
            end
            OP_LOGIC: begin
               if (insn[5]) res = a & imm5;
               else if (insn[4:3] == 2'b00) res = a & regs[insn[2:0]];
               else if (insn[4:3] == 2'b10) res = a | regs[insn[2:0]];
               else if (insn[4:3] == 2'b11) res = a ^ regs[insn[2:0]];
               else wr = 1'b0;
            end
            OP_LDR: res = mmem[addr];
            OP_STR: begin
               wr = 1'b0;
               mmem[addr] = regs[insn[11:9]];
               exp_addr.push_back(addr);
               exp_store.push_back(regs[insn[11:9]]);
            end
            OP_CONST: res = imm9;
            OP_BR: begin
               wr = 1'b0;
               // Taken branch skips imm9 instructions past the next one
               if ((insn[11:9] & nzp) != 3'b000) idx = idx + int'($signed(insn[8:0]));
            end
            default: wr = 1'b0;
         endcase
         if (wr) begin
            regs[insn[11:9]] = res;
            nzp = {res[15], res == '0, !res[15] && (res != '0)};
            exp_sel.push_back(insn[11:9]);
            exp_data.push_back(res);
            exp_pc.push_back(RESET_PC + word_t'(idx));
         end
         idx++;
         steps++;
      end
   endtask

   task automatic start_reset();
      @(posedge gwe);
      #1;
      rst_n = 1'b0;
   endtask

   // Two cycles in reset before the idle state is checked
   task automatic release_reset();
      repeat (2) @(posedge gwe);
      #1;
      rst_n = 1'b1;
      @(negedge gwe);
      check_word("o_cur_pc", cur_pc, RESET_PC);
      check_bit("o_dmem_we", dmem_we, 1'b0);
      check_bit("o_wb_we", wb_we, 1'b0);
   endtask

   // Loads prog under reset and waits for the end marker to retire
   task automatic run_program(input string name);
      int n;
      start_reset();
      prog.push_back(wide_form(OP_CONST, 3'd0, 9'h0A5));
      for (int i = 0; i < IMEM_N; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : '0;
      end
      for (int i = 0; i < DMEM_N; i++) begin
         dmem[i] = fill_word(word_t'(i));
         mmem[i] = dmem[i];
      end
      run_model();
      tr_idx = 0;
      st_idx = 0;
      n = exp_sel.size();
      release_reset();
      while (tr_idx < n) @(posedge gwe);
      check_word("store count", word_t'(st_idx), word_t'(exp_addr.size()));
      $display("%s: %0d retired, %0d stores", name, tr_idx, st_idx);
      prog.delete();
   endtask

   task automatic check_after_reset();
      start_reset();
      release_reset();
   endtask

   // Each result feeds the next through M, W and write-through
   task automatic alu_chain();
      prog.push_back(wide_form(OP_CONST, 3'd1, 9'h1FD));
      prog.push_back(reg_form(OP_ARITH, 3'd2, 3'd1, 3'b000, 3'd1));
      prog.push_back(reg_form(OP_ARITH, 3'd3, 3'd2, 3'b010, 3'd1));
      prog.push_back(imm5_form(OP_ARITH, 3'd4, 3'd3, 5'd7));
      prog.push_back(reg_form(OP_LOGIC, 3'd5, 3'd4, 3'b000, 3'd3));
      prog.push_back(reg_form(OP_LOGIC, 3'd6, 3'd5, 3'b010, 3'd2));
      prog.push_back(reg_form(OP_LOGIC, 3'd7, 3'd6, 3'b011, 3'd1));
      prog.push_back(imm5_form(OP_LOGIC, 3'd1, 3'd7, 5'h1E));
      prog.push_back(reg_form(OP_ARITH, 3'd2, 3'd1, 3'b000, 3'd4));
      prog.push_back(reg_form(OP_ARITH, 3'd0, 3'd6, 3'b010, 3'd1));
      prog.push_back(reg_form(OP_LOGIC, 3'd5, 3'd0, 3'b011, 3'd1));
      run_program("alu chain");
   endtask

   // Store then load back with load-to-use stalls and store data from W
   task automatic store_load_pair();
      prog.push_back(wide_form(OP_CONST, 3'd1, 9'h040));
      prog.push_back(wide_form(OP_CONST, 3'd2, 9'h19C));
      prog.push_back(mem_form(OP_STR, 3'd2, 3'd1, 6'd3));
      prog.push_back(mem_form(OP_LDR, 3'd3, 3'd1, 6'd3));
      prog.push_back(reg_form(OP_ARITH, 3'd4, 3'd3, 3'b000, 3'd1));
      prog.push_back(mem_form(OP_LDR, 3'd5, 3'd1, 6'd0));
      prog.push_back(mem_form(OP_STR, 3'd5, 3'd1, 6'd5));
      prog.push_back(mem_form(OP_LDR, 3'd6, 3'd1, 6'd5));
      prog.push_back(imm5_form(OP_ARITH, 3'd7, 3'd6, 5'd1));
      run_program("store and load");
   endtask

   // NZP from M, W, the register and from load data
   task automatic branch_paths();
      prog.push_back(wide_form(OP_CONST, 3'd1, 9'h1FF));
      prog.push_back(wide_form(OP_BR, 3'b100, 9'd1));
      prog.push_back(wide_form(OP_CONST, 3'd2, 9'h011));
      prog.push_back(wide_form(OP_BR, 3'b010, 9'd1));
      prog.push_back(wide_form(OP_CONST, 3'd3, 9'h000));
      prog.push_back(wide_form(OP_BR, 3'b011, 9'd1));
      prog.push_back(reg_form(OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd1));
      prog.push_back(wide_form(OP_CONST, 3'd1, 9'h040));
      prog.push_back(wide_form(OP_CONST, 3'd5, 9'h005));
      prog.push_back(mem_form(OP_STR, 3'd5, 3'd1, 6'd2));
      prog.push_back(mem_form(OP_LDR, 3'd4, 3'd1, 6'd2));
      prog.push_back(wide_form(OP_BR, 3'b001, 9'd1));
      prog.push_back(wide_form(OP_CONST, 3'd6, 9'h022));
      prog.push_back(mem_form(OP_LDR, 3'd4, 3'd1, 6'd9));
      prog.push_back(wide_form(OP_BR, 3'b110, 9'd1));
      prog.push_back(wide_form(OP_CONST, 3'd6, 9'h033));
      prog.push_back(wide_form(OP_CONST, 3'd7, 9'h000));
      prog.push_back(mem_form(OP_STR, 3'd7, 3'd1, 6'd0));
      prog.push_back(wide_form(OP_BR, 3'b010, 9'd1));
      // Wrong-path store
      prog.push_back(mem_form(OP_STR, 3'd1, 3'd1, 6'd1));
      prog.push_back(wide_form(OP_CONST, 3'd2, 9'h003));
      prog.push_back(mem_form(OP_STR, 3'd2, 3'd1, 6'd6));
      prog.push_back(mem_form(OP_STR, 3'd2, 3'd1, 6'd7));
      prog.push_back(wide_form(OP_BR, 3'b001, 9'd1));
      prog.push_back(wide_form(OP_CONST, 3'd2, 9'h044));
      prog.push_back(wide_form(OP_BR, 3'b100, 9'd1));
      prog.push_back(imm5_form(OP_ARITH, 3'd3, 3'd2, 5'h1C));
      run_program("branches");
   endtask

   task automatic random_program();
      logic [3:0] kind;
      reg_sel_t   d, s, t;
      for (int i = 0; i < N_RAND; i++) begin
         kind = 4'(lfsr_bits(4) % 9);
         d    = reg_sel_t'(lfsr_bits(3));
         s    = reg_sel_t'(lfsr_bits(3));
         t    = reg_sel_t'(lfsr_bits(3));
         case (kind)
            4'd0: prog.push_back(reg_form(OP_ARITH, d, s, 3'b000, t));
            4'd1: prog.push_back(reg_form(OP_ARITH, d, s, 3'b010, t));
            4'd2: prog.push_back(imm5_form(OP_ARITH, d, s, 5'(lfsr_bits(5))));
            4'd3: prog.push_back(reg_form(OP_LOGIC, d, s, 3'b000, t));
            4'd4: prog.push_back(reg_form(OP_LOGIC, d, s, 3'b010, t));
            4'd5: prog.push_back(reg_form(OP_LOGIC, d, s, 3'b011, t));
            4'd6: prog.push_back(imm5_form(OP_LOGIC, d, s, 5'(lfsr_bits(5))));
            4'd7: prog.push_back(wide_form(OP_CONST, d, lfsr_bits(9)));
            default: prog.push_back(mem_form(OP_STR, d, s, 6'(lfsr_bits(6))));
         endcase
      end
      run_program("random");
   endtask

   // Memories answer 1 ns after each edge
   always @(posedge gwe) begin
      #1;
      cur_insn  = fetch_insn(cur_pc);
      dmem_data = dmem[dmem_addr];
   end

   // Trace monitor sampling mid-cycle
   always @(negedge gwe) begin
      if (wb_we === 1'b1) begin
         if (tr_idx >= exp_sel.size()) begin
            $display("Unexpected retire at pc %h beyond the end of the program", wb_pc);
            stop_on_error();
         end else begin
            check_sel("o_wb_sel", wb_sel, exp_sel[tr_idx]);
            check_word("o_wb_data", wb_data, exp_data[tr_idx]);
            check_word("o_wb_pc", wb_pc, exp_pc[tr_idx]);
            tr_idx++;
         end
      end
   end

   // Store monitor that also performs the write
   always @(negedge gwe) begin
      if (dmem_we === 1'b1) begin
         if (st_idx >= exp_addr.size()) begin
            $display("Unexpected store to address %h off the program path", dmem_addr);
            stop_on_error();
         end else begin
            check_word("o_dmem_addr", dmem_addr, exp_addr[st_idx]);
            check_word("o_dmem_towrite", dmem_towrite, exp_store[st_idx]);
            dmem[dmem_addr] = dmem_towrite;
            st_idx++;
         end
      end
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the pipeline never retired the program in %0d cycles",
               WATCHDOG_CYCLES);
      stop_on_error();
   end

   initial begin
      gwe        = 1'b0;
      rst_n      = 1'b0;
      cur_insn   = '0;
      dmem_data  = '0;
      lfsr_state = 16'd11;
      tr_idx     = 0;
      st_idx     = 0;
      for (int i = 0; i < IMEM_N; i++) begin
         imem[i] = '0;
      end
      check_after_reset();
      alu_chain();
      store_load_pair();
      branch_paths();
      random_program();
      $display("sim passed");
      $finish;
   end

endmodule

// File: source/lc4_processor.sv
/*
   LC4 five-stage pipelined processor
   Fetch, decode, execute, memory and writeback with bypassing,
   load-to-use stall, branch flush in execute and a writeback trace port
*/
`timescale 1ns/1ps

module lc4_processor import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   output word_t    o_cur_pc,
   input  word_t    i_cur_insn,
   output word_t    o_dmem_addr,
   input  word_t    i_cur_dmem_data,
   output logic     o_dmem_we,
   output word_t    o_dmem_towrite,
   output logic     o_wb_we,
   output reg_sel_t o_wb_sel,
   output word_t    o_wb_data,
   output word_t    o_wb_pc
);

   // Fetch
   word_t    pc;
   word_t    next_pc;
   logic     stall;
   logic     x_taken;
   // Decode
   logic     d_valid;
   word_t    d_insn, d_pc, d_rs_data, d_rt_data;
   reg_sel_t d_r1sel, d_r2sel, d_wsel;
   logic     d_r1re, d_r2re, d_regfile_we, d_nzp_we;
   logic     d_is_load, d_is_store, d_is_branch;
   alu_op_e  d_alu_op;
   // Execute
   logic     x_valid;
   word_t    x_insn, x_pc, x_rs_data, x_rt_data, x_rs, x_rt, x_alu;
   reg_sel_t x_r1sel, x_r2sel, x_wsel;
   logic     x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
   alu_op_e  x_alu_op;
   fwd_sel_e fwd_x_rs, fwd_x_rt;
   nzp_t     br_nzp;
   // Memory
   logic     m_valid;
   word_t    m_pc, m_alu, m_rt_data, m_result;
   reg_sel_t m_wsel, m_r2sel;
   logic     m_regfile_we, m_nzp_we, m_is_load, m_is_store, fwd_m_rt;
   // Writeback
   logic     w_valid;
   word_t    w_pc, w_wdata;
   reg_sel_t w_wsel;
   logic     w_regfile_we, w_nzp_we, w_rf_write;
   nzp_t     nzp_reg;

   function automatic nzp_t nzp_of(input word_t v);
      return {v[WORD_W-1], v == '0, !v[WORD_W-1] && (v != '0)};
   endfunction

   function automatic word_t bypass(input fwd_sel_e sel, input word_t rf,
                                    input word_t m_val, input word_t w_val);
      case (sel)
         FWD_M:   return m_val;
         FWD_W:   return w_val;
         default: return rf;
      endcase
   endfunction

   // Redirect beats stall beats sequential
   assign next_pc  = x_taken ? x_alu : (stall ? pc : pc + word_t'(1));
   assign o_cur_pc = pc;

   lc4_decoder lc4_decoder_inst (
      .i_insn       (d_insn),
      .o_r1sel      (d_r1sel),
      .o_r2sel      (d_r2sel),
      .o_wsel       (d_wsel),
      .o_r1re       (d_r1re),
      .o_r2re       (d_r2re),
      .o_regfile_we (d_regfile_we),
      .o_nzp_we     (d_nzp_we),
      .o_is_load    (d_is_load),
      .o_is_store   (d_is_store),
      .o_is_branch  (d_is_branch),
      .o_alu_op     (d_alu_op)
   );

   // Written from W with write-through covering W-to-D
   lc4_regfile lc4_regfile_inst (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (d_r1sel),
      .i_rt      (d_r2sel),
      .i_rd      (w_wsel),
      .i_wdata   (w_wdata),
      .i_rd_we   (w_rf_write),
      .o_rs_data (d_rs_data),
      .o_rt_data (d_rt_data)
   );

   // Control flags qualified by stage valid
   lc4_hazard_unit lc4_hazard_unit_inst (
      .i_d_r1sel      (d_r1sel),
      .i_d_r2sel      (d_r2sel),
      .i_x_r1sel      (x_r1sel),
      .i_x_r2sel      (x_r2sel),
      .i_x_wsel       (x_wsel),
      .i_m_wsel       (m_wsel),
      .i_m_r2sel      (m_r2sel),
      .i_w_wsel       (w_wsel),
      .i_d_r1re       (d_valid && d_r1re),
      .i_d_r2re       (d_valid && d_r2re),
      .i_d_is_store   (d_is_store),
      .i_x_regfile_we (x_valid && x_regfile_we),
      .i_x_is_load    (x_valid && x_is_load),
      .i_m_regfile_we (m_valid && m_regfile_we),
      .i_m_is_load    (m_valid && m_is_load),
      .i_m_is_store   (m_valid && m_is_store),
      .i_w_regfile_we (w_rf_write),
      .o_stall        (stall),
      .o_fwd_x_rs     (fwd_x_rs),
      .o_fwd_x_rt     (fwd_x_rt),
      .o_fwd_m_rt     (fwd_m_rt)
   );

   // Execute operands after bypass
   assign x_rs = bypass(fwd_x_rs, x_rs_data, m_alu, w_wdata);
   assign x_rt = bypass(fwd_x_rt, x_rt_data, m_alu, w_wdata);

   lc4_alu lc4_alu_inst (
      .i_alu_op (x_alu_op),
      .i_insn   (x_insn),
      .i_pc     (x_pc),
      .i_rs     (x_rs),
      .i_rt     (x_rt),
      .o_result (x_alu)
   );

   // NZP of the youngest older writer
   // A load in M supplies memory data directly
   always_comb begin
      if (m_valid && m_nzp_we) begin
         br_nzp = nzp_of(m_result);
      end else if (w_valid && w_nzp_we) begin
         br_nzp = nzp_of(w_wdata);
      end else begin
         br_nzp = nzp_reg;
      end
   end

   assign x_taken = x_valid && x_is_branch && ((x_insn[11:9] & br_nzp) != 3'b000);

   // Memory stage
   assign m_result       = m_is_load ? i_cur_dmem_data : m_alu;
   assign o_dmem_addr    = m_alu;
   assign o_dmem_we      = m_valid && m_is_store;
   assign o_dmem_towrite = fwd_m_rt ? w_wdata : m_rt_data;

   // Writeback and trace
   assign w_rf_write = w_valid && w_regfile_we;
   assign o_wb_we    = w_rf_write;
   assign o_wb_sel   = w_wsel;
   assign o_wb_data  = w_wdata;
   assign o_wb_pc    = w_pc;

   // PC, valid bits and NZP
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc      <= RESET_PC;
         d_valid <= 1'b0;
         x_valid <= 1'b0;
         m_valid <= 1'b0;
         w_valid <= 1'b0;
         nzp_reg <= '0;
      end else begin
         pc <= next_pc;
         // Flush kills F and stall holds D
         if (x_taken) begin
            d_valid <= 1'b0;
         end else if (!stall) begin
            d_valid <= 1'b1;
         end
         // Bubble into X on stall or flush
         x_valid <= d_valid && !stall && !x_taken;
         m_valid <= x_valid;
         w_valid <= m_valid;
         if (w_valid && w_nzp_we) begin
            nzp_reg <= nzp_of(w_wdata);
         end
      end
   end

   // Pipeline payload
   always_ff @(posedge gwe) begin
      if (!stall) begin
         d_insn <= i_cur_insn;
         d_pc   <= pc;
      end
      x_insn       <= d_insn;
      x_pc         <= d_pc;
      x_rs_data    <= d_rs_data;
      x_rt_data    <= d_rt_data;
      x_r1sel      <= d_r1sel;
      x_r2sel      <= d_r2sel;
      x_wsel       <= d_wsel;
      x_regfile_we <= d_regfile_we;
      x_nzp_we     <= d_nzp_we;
      x_is_load    <= d_is_load;
      x_is_store   <= d_is_store;
      x_is_branch  <= d_is_branch;
      x_alu_op     <= d_alu_op;
      m_pc         <= x_pc;
      m_alu        <= x_alu;
      m_rt_data    <= x_rt;
      m_wsel       <= x_wsel;
      m_r2sel      <= x_r2sel;
      m_regfile_we <= x_regfile_we;
      m_nzp_we     <= x_nzp_we;
      m_is_load    <= x_is_load;
      m_is_store   <= x_is_store;
      w_pc         <= m_pc;
      w_wdata      <= m_result;
      w_wsel       <= m_wsel;
      w_regfile_we <= m_regfile_we;
      w_nzp_we     <= m_nzp_we;
   end

   // Store write only from a valid M that came out of a valid X
   a_store_valid: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> m_valid && $past(x_valid))
      else $error("data memory write from an invalid stage");

   // Neither younger instruction of a taken branch reaches M
   a_flush: assert property (@(posedge gwe) disable iff (!i_rst_n)
      ($past(x_taken, 2) || $past(x_taken, 3)) |-> !m_valid)
      else $error("younger instructions survived a taken branch");

endmodule

// File: source/lc4_hazard_unit.sv
/*
   LC4 hazard unit
   Load-to-use stall detection and bypass source selection for the
   execute operands and the store data in memory stage
*/
`timescale 1ns/1ps

module lc4_hazard_unit import lc4_pkg::*; (
   input  reg_sel_t i_d_r1sel,
   input  reg_sel_t i_d_r2sel,
   input  reg_sel_t i_x_r1sel,
   input  reg_sel_t i_x_r2sel,
   input  reg_sel_t i_x_wsel,
   input  reg_sel_t i_m_wsel,
   input  reg_sel_t i_m_r2sel,
   input  reg_sel_t i_w_wsel,
   input  logic     i_d_r1re,
   input  logic     i_d_r2re,
   input  logic     i_d_is_store,
   input  logic     i_x_regfile_we,
   input  logic     i_x_is_load,
   input  logic     i_m_regfile_we,
   input  logic     i_m_is_load,
   input  logic     i_m_is_store,
   input  logic     i_w_regfile_we,
   output logic     o_stall,
   output fwd_sel_e o_fwd_x_rs,
   output fwd_sel_e o_fwd_x_rt,
   output logic     o_fwd_m_rt
);

   logic m_fwd_ok;

   // Load in X feeding a register read in D
   // Store data skips this, W-to-M bypass catches it later
   assign o_stall = i_x_is_load && i_x_regfile_we &&
                    ((i_d_r1re && (i_d_r1sel == i_x_wsel)) ||
                     (i_d_r2re && !i_d_is_store && (i_d_r2sel == i_x_wsel)));

   // Load data is not ready in M for an execute bypass
   assign m_fwd_ok = i_m_regfile_we && !i_m_is_load;

   // Youngest writer first: M, then W, then captured value
   assign o_fwd_x_rs = (m_fwd_ok && (i_m_wsel == i_x_r1sel))       ? FWD_M :
                       (i_w_regfile_we && (i_w_wsel == i_x_r1sel)) ? FWD_W : FWD_RF;
   assign o_fwd_x_rt = (m_fwd_ok && (i_m_wsel == i_x_r2sel))       ? FWD_M :
                       (i_w_regfile_we && (i_w_wsel == i_x_r2sel)) ? FWD_W : FWD_RF;

   // Store data from the instruction just ahead, typically a load
   assign o_fwd_m_rt = i_m_is_store && i_w_regfile_we && (i_w_wsel == i_m_r2sel);

   // No M bypass while M holds a load
   a_no_load_fwd: assert final (!(i_m_is_load &&
                                  ((o_fwd_x_rs == FWD_M) || (o_fwd_x_rt == FWD_M))))
      else $error("M-stage bypass selected for a load");

   // Stall only behind a load in X
   a_stall_load: assert final (!o_stall || i_x_is_load)
      else $error("stall without a load in execute");

endmodule

// File: source/lc4_alu.sv
/*
   LC4 execute ALU
   Arithmetic and logic results, CONST values, load/store addresses
   and branch targets from one operation code
*/
`timescale 1ns/1ps

module lc4_alu import lc4_pkg::*; (
   input  alu_op_e i_alu_op,
   input  word_t   i_insn,
   input  word_t   i_pc,
   input  word_t   i_rs,
   input  word_t   i_rt,
   output word_t   o_result
);

   word_t imm5;
   word_t imm6;
   word_t imm9;

   // Sign-extended immediates
   assign imm5 = {{(WORD_W-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{(WORD_W-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{(WORD_W-9){i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (i_alu_op)
         // Register forms
         ALU_ADD:   o_result = i_rs + i_rt;
         ALU_SUB:   o_result = i_rs - i_rt;
         ALU_AND:   o_result = i_rs & i_rt;
         ALU_OR:    o_result = i_rs | i_rt;
         ALU_XOR:   o_result = i_rs ^ i_rt;
         // Immediate forms use imm5
         ALU_ADDI:  o_result = i_rs + imm5;
         ALU_ANDI:  o_result = i_rs & imm5;
         ALU_CONST: o_result = imm9;
         // Effective address for LDR and STR
         ALU_MEM:   o_result = i_rs + imm6;
         // Target relative to the next instruction
         ALU_BR:    o_result = i_pc + word_t'(1) + imm9;
         default:   o_result = '0;
      endcase
   end

endmodule

// File: source/lc4_regfile.sv
/*
   LC4 register file
   Eight words, two combinational read ports and one write port;
   a same-cycle write is seen on the read ports
*/
`timescale 1ns/1ps

module lc4_regfile import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  reg_sel_t i_rs,
   input  reg_sel_t i_rt,
   input  reg_sel_t i_rd,
   input  word_t    i_wdata,
   input  logic     i_rd_we,
   output word_t    o_rs_data,
   output word_t    o_rt_data
);

   word_t regs [REG_N];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Write-through
   // Writeback result reaches decode in the same cycle
   assign o_rs_data = (i_rd_we && (i_rd == i_rs)) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && (i_rd == i_rt)) ? i_wdata : regs[i_rt];

endmodule

// File: source/lc4_decoder.sv
/*
   LC4 instruction decoder
   Splits an instruction into register selects, read and write enables,
   memory and branch flags and the ALU operation
*/
`timescale 1ns/1ps

module lc4_decoder import lc4_pkg::*; (
   input  word_t    i_insn,
   output reg_sel_t o_r1sel,
   output reg_sel_t o_r2sel,
   output reg_sel_t o_wsel,
   output logic     o_r1re,
   output logic     o_r2re,
   output logic     o_regfile_we,
   output logic     o_nzp_we,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_is_branch,
   output alu_op_e  o_alu_op
);

   always_comb begin
      // Field positions common to all formats
      o_r1sel      = i_insn[8:6];
      o_wsel       = i_insn[11:9];
      // STR keeps its data register where rd normally is
      o_r2sel      = (i_insn[15:12] == OP_STR) ? i_insn[11:9] : i_insn[2:0];
      // Default is a NOP with no flag set
      o_is_load    = 1'b0;
      o_is_store   = 1'b0;
      o_is_branch  = 1'b0;
      o_alu_op     = ALU_NOP;
      case (opcode_e'(i_insn[15:12]))
         OP_BR: begin
            // Empty mask is the NOP encoding
            if (i_insn[11:9] != 3'b000) begin
               o_is_branch = 1'b1;
               o_alu_op    = ALU_BR;
            end
         end
         OP_ARITH: begin
            casez (i_insn[5:3])
               3'b000: o_alu_op = ALU_ADD;
               3'b010: o_alu_op = ALU_SUB;
               3'b1??: o_alu_op = ALU_ADDI;
               // MUL and DIV dropped
               default: o_alu_op = ALU_NOP;
            endcase
         end
         OP_LOGIC: begin
            casez (i_insn[5:3])
               3'b000: o_alu_op = ALU_AND;
               3'b010: o_alu_op = ALU_OR;
               3'b011: o_alu_op = ALU_XOR;
               3'b1??: o_alu_op = ALU_ANDI;
               // NOT dropped
               default: o_alu_op = ALU_NOP;
            endcase
         end
         OP_LDR: begin
            o_alu_op  = ALU_MEM;
            o_is_load = 1'b1;
         end
         OP_STR: begin
            o_alu_op   = ALU_MEM;
            o_is_store = 1'b1;
         end
         OP_CONST: o_alu_op = ALU_CONST;
         default: o_alu_op = ALU_NOP;
      endcase
      // Enables follow from the chosen operation
      o_r1re       = !(o_alu_op inside {ALU_NOP, ALU_CONST, ALU_BR});
      // Immediate forms read rs only
      o_r2re       = (o_alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR}) || o_is_store;
      o_regfile_we = !(o_alu_op inside {ALU_NOP, ALU_BR}) && !o_is_store;
   end

   // Every register writer also sets NZP
   assign o_nzp_we = o_regfile_we;

endmodule

// File: source/lc4_pkg.sv
/*
   LC4 shared definitions
   Word and register sizes, reset vector, opcode and ALU operation
   encodings, and the operand bypass sources
*/
package lc4_pkg;

   // Machine word, both data and instruction
   localparam int WORD_W = 16;

   // Register file depth
   localparam int REG_N = 8;
   localparam int SEL_W = $clog2(REG_N);

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [SEL_W-1:0]  reg_sel_t;

   // Condition bits, MSB is negative
   typedef logic [2:0] nzp_t;

   // First fetch after reset
   localparam word_t RESET_PC = 16'h8200;

   // Major opcode, instruction bits 15..12
   // Only the kept subset, everything else is a NOP
   typedef enum logic [3:0] {
      OP_BR    = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   // Operation carried down the pipe to the execute stage
   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_SUB   = 4'd1,
      ALU_ADDI  = 4'd2,
      ALU_AND   = 4'd3,
      ALU_OR    = 4'd4,
      ALU_XOR   = 4'd5,
      ALU_ANDI  = 4'd6,
      // Sign-extended imm9
      ALU_CONST = 4'd7,
      // Base plus sext imm6, used by LDR and STR
      ALU_MEM   = 4'd8,
      // PC+1 plus sext imm9
      ALU_BR    = 4'd9,
      ALU_NOP   = 4'd15
   } alu_op_e;

   // Where an execute operand comes from
   typedef enum logic [1:0] {
      // Value captured in decode
      FWD_RF = 2'd0,
      // ALU result sitting in memory stage
      FWD_M  = 2'd1,
      // Writeback value
      FWD_W  = 2'd2
   } fwd_sel_e;

endpackage
